// ==== dcache_geom_pkg.sv ====
// cache geometry constants and width typedefs
package dcache_geom_pkg;

    // fixed geometry
    localparam int N_WAYS      = 4;
    localparam int LINE_BYTES  = 16;
    localparam int OFFSET_BITS = 4;   // byte offset inside a line

    // one line byte
    typedef logic [7:0] byte_t;

    // full line, byte 0 in the low bits
    typedef logic [LINE_BYTES*8-1:0] line_t;

    // one enable per line byte
    typedef logic [LINE_BYTES-1:0] byte_en_t;

    // one bit per way, used for hit and evict selects
    typedef logic [N_WAYS-1:0] way_mask_t;

    // encoded way number
    typedef logic [1:0] way_idx_t;

    // byte address
    typedef logic [31:0] addr_t;

endpackage

// ==== dcache_req_pkg.sv ====
// lane request and registered lane state structs
package dcache_req_pkg;

    // one load/store lane request, sampled every frame
    typedef struct packed {
        dcache_geom_pkg::way_mask_t way_en;     // hit way, at most one-hot
        dcache_geom_pkg::way_mask_t evict_en;   // way to evict, at most one-hot
        dcache_geom_pkg::byte_en_t  byte_en;    // bytes to store
        dcache_geom_pkg::addr_t     addr;
        dcache_geom_pkg::line_t     wr_line;
    } lane_req_t;

    // cycle-1 state of one lane
    typedef struct packed {
        dcache_geom_pkg::way_idx_t  hit_way;
        dcache_geom_pkg::way_idx_t  evict_way;
        logic                       evicted;    // lane evicts this frame
        dcache_geom_pkg::byte_en_t  own_mask;   // bytes this lane writes
        dcache_geom_pkg::line_t     wr_line;
    } lane_stage_t;

endpackage

// ==== dcache_req_stage.sv ====
// way encoding, cycle-1 lane registers and per-way write strobes
`timescale 1ns/1ps

module dcache_req_stage #(
    parameter  int N_LANES = 4,
    parameter  int N_SETS  = 16,
    localparam int IDX_W   = $clog2(N_SETS)
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  dcache_req_pkg::lane_req_t    req      [N_LANES-1:0],
    output dcache_req_pkg::lane_stage_t  stage    [N_LANES-1:0],
    output dcache_geom_pkg::byte_en_t    wr_mask  [dcache_geom_pkg::N_WAYS-1:0][N_LANES-1:0],
    output logic [IDX_W-1:0]             wr_index [N_LANES-1:0],
    output dcache_geom_pkg::line_t       wr_data  [N_LANES-1:0]
);

    dcache_geom_pkg::way_idx_t hit_way_d   [N_LANES-1:0];
    dcache_geom_pkg::way_idx_t evict_way_d [N_LANES-1:0];
    dcache_geom_pkg::way_idx_t hit_way_q   [N_LANES-1:0];
    dcache_geom_pkg::way_idx_t evict_way_q [N_LANES-1:0];
    dcache_geom_pkg::byte_en_t own_mask_q  [N_LANES-1:0];
    logic [N_LANES-1:0]        evicted_q;

    // one-hot to binary
    // idle lanes encode as way 0
    always_comb begin
        for (int l = 0; l < N_LANES; l++) begin
            hit_way_d[l]   = '0;
            evict_way_d[l] = '0;
            for (int w = 0; w < dcache_geom_pkg::N_WAYS; w++) begin
                if (req[l].way_en[w]) begin
                    hit_way_d[l] = dcache_geom_pkg::way_idx_t'(w);
                end
                if (req[l].evict_en[w]) begin
                    evict_way_d[l] = dcache_geom_pkg::way_idx_t'(w);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int l = 0; l < N_LANES; l++) begin
                hit_way_q[l]   <= '0;
                evict_way_q[l] <= '0;
                own_mask_q[l]  <= '0;
                evicted_q[l]   <= 1'b0;
                for (int w = 0; w < dcache_geom_pkg::N_WAYS; w++) begin
                    wr_mask[w][l] <= '0;
                end
            end
        end else begin
            for (int l = 0; l < N_LANES; l++) begin
                hit_way_q[l]   <= hit_way_d[l];
                evict_way_q[l] <= evict_way_d[l];
                evicted_q[l]   <= |req[l].evict_en;
                own_mask_q[l]  <= (|req[l].way_en) ? req[l].byte_en : '0;  // only a hit lane writes
                for (int w = 0; w < dcache_geom_pkg::N_WAYS; w++) begin
                    wr_mask[w][l] <= req[l].way_en[w] ? req[l].byte_en : '0;
                end
            end
        end
    end

    // write index and line for the array strobes
    always_ff @(posedge clk) begin
        for (int l = 0; l < N_LANES; l++) begin
            wr_index[l] <= req[l].addr[dcache_geom_pkg::OFFSET_BITS +: IDX_W];
            wr_data[l]  <= req[l].wr_line;
        end
    end

    for (genvar l = 0; l < N_LANES; l++) begin : g_lane
        assign stage[l] = '{hit_way:   hit_way_q[l],
                            evict_way: evict_way_q[l],
                            evicted:   evicted_q[l],
                            own_mask:  own_mask_q[l],
                            wr_line:   wr_data[l]};

        // encoders assume at most one way per select
        a_way_onehot: assert property (@(posedge clk) disable iff (!arst_n)
            $onehot0(req[l].way_en))
            else $error("lane %0d: way_en has more than one bit set", l);
        a_evict_onehot: assert property (@(posedge clk) disable iff (!arst_n)
            $onehot0(req[l].evict_en))
            else $error("lane %0d: evict_en has more than one bit set", l);
    end

endmodule

// ==== way_data_array.sv ====
// multiported byte-enabled line array for one way
`timescale 1ns/1ps

module way_data_array #(
    parameter  int N_LANES = 4,
    parameter  int N_SETS  = 16,
    localparam int IDX_W   = $clog2(N_SETS)
) (
    input  logic                       clk,
    input  dcache_geom_pkg::byte_en_t  wr_mask  [N_LANES-1:0],   // already gated by this way
    input  logic [IDX_W-1:0]           wr_index [N_LANES-1:0],
    input  dcache_geom_pkg::line_t     wr_data  [N_LANES-1:0],
    input  logic [IDX_W-1:0]           rd_index [N_LANES-1:0],
    output dcache_geom_pkg::line_t     rd_data  [N_LANES-1:0]
);

    localparam int NB = dcache_geom_pkg::LINE_BYTES;

    // byte-wide storage so every lane can write its own bytes
    dcache_geom_pkg::byte_t mem [N_SETS-1:0][NB-1:0];

    dcache_geom_pkg::line_t rd_next [N_LANES-1:0];

    // lanes applied in order, last (highest) lane wins a shared byte
    always_ff @(posedge clk) begin
        for (int l = 0; l < N_LANES; l++) begin
            for (int b = 0; b < NB; b++) begin
                if (wr_mask[l][b]) begin
                    mem[wr_index[l]][b] <= wr_data[l][b*8 +: 8];
                end
            end
        end
    end

    // read-after-write bypass
    // a byte committing at this edge replaces the stale array byte
    always_comb begin
        for (int r = 0; r < N_LANES; r++) begin
            for (int b = 0; b < NB; b++) begin
                rd_next[r][b*8 +: 8] = mem[rd_index[r]][b];
                for (int l = 0; l < N_LANES; l++) begin
                    if (wr_mask[l][b] && wr_index[l] == rd_index[r]) begin
                        rd_next[r][b*8 +: 8] = wr_data[l][b*8 +: 8];  // same priority as the write
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < N_LANES; r++) begin
            rd_data[r] <= rd_next[r];
        end
    end

    for (genvar l = 0; l < N_LANES; l++) begin : g_chk
        // index comes registered from the request stage
        a_wr_index_known: assert property (@(posedge clk)
            (|wr_mask[l]) |-> !$isunknown(wr_index[l]))
            else $error("lane %0d: unknown write index with active byte mask", l);
    end

endmodule

// ==== lane_forward_match.sv ====
// registered same-frame forward masks between lane pairs
`timescale 1ns/1ps

module lane_forward_match #(
    parameter  int N_LANES = 4,
    parameter  int N_SETS  = 16,
    localparam int IDX_W   = $clog2(N_SETS)
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  dcache_req_pkg::lane_req_t  req    [N_LANES-1:0],
    output dcache_geom_pkg::byte_en_t  rd_fwd [N_LANES-1:0][N_LANES-1:0],  // [later][earlier]
    output dcache_geom_pkg::byte_en_t  ev_fwd [N_LANES-1:0][N_LANES-1:0]
);

    logic [IDX_W-1:0]          idx      [N_LANES-1:0];
    dcache_geom_pkg::byte_en_t wr_bytes [N_LANES-1:0];

    // set index and bytes each lane actually stores this frame
    always_comb begin
        for (int l = 0; l < N_LANES; l++) begin
            idx[l]      = req[l].addr[dcache_geom_pkg::OFFSET_BITS +: IDX_W];
            wr_bytes[l] = (|req[l].way_en) ? req[l].byte_en : '0;
        end
    end

    // one-hot masks, so mask equality is way equality
    // a nonzero writer mask keeps idle later lanes from matching
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N_LANES; i++) begin
                for (int j = 0; j < N_LANES; j++) begin
                    rd_fwd[i][j] <= '0;
                    ev_fwd[i][j] <= '0;
                end
            end
        end else begin
            for (int i = 0; i < N_LANES; i++) begin
                for (int j = 0; j < N_LANES; j++) begin
                    if (j < i && idx[j] == idx[i]) begin
                        rd_fwd[i][j] <= (req[j].way_en == req[i].way_en)   ? wr_bytes[j] : '0;
                        ev_fwd[i][j] <= (req[j].way_en == req[i].evict_en) ? wr_bytes[j] : '0;
                    end else begin
                        rd_fwd[i][j] <= '0;  // only earlier lanes forward
                        ev_fwd[i][j] <= '0;
                    end
                end
            end
        end
    end

endmodule

// ==== lane_line_select.sv ====
// cycle-1 read line and evict line selection per lane
`timescale 1ns/1ps

module lane_line_select #(
    parameter int N_LANES = 4
) (
    input  dcache_req_pkg::lane_stage_t  stage      [N_LANES-1:0],
    input  dcache_geom_pkg::byte_en_t    rd_fwd     [N_LANES-1:0][N_LANES-1:0],
    input  dcache_geom_pkg::byte_en_t    ev_fwd     [N_LANES-1:0][N_LANES-1:0],
    input  dcache_geom_pkg::line_t       way_lines  [dcache_geom_pkg::N_WAYS-1:0][N_LANES-1:0],
    output dcache_geom_pkg::line_t       rd_line    [N_LANES-1:0],
    output dcache_geom_pkg::line_t       evict_line [N_LANES-1:0],
    output logic [N_LANES-1:0]           evicted
);

    localparam int NB = dcache_geom_pkg::LINE_BYTES;

    // lanes resolved in order so a later lane can pick up an
    // earlier lane's finished read byte
    always_comb begin
        dcache_geom_pkg::byte_t rd_b;
        dcache_geom_pkg::byte_t ev_b;
        for (int i = 0; i < N_LANES; i++) begin
            for (int b = 0; b < NB; b++) begin
                rd_b = way_lines[stage[i].hit_way][i][b*8 +: 8];
                ev_b = stage[i].evicted ? way_lines[stage[i].evict_way][i][b*8 +: 8] : '0;
                // ascending scan, highest forwarding lane ends up on top
                for (int j = 0; j < i; j++) begin
                    if (rd_fwd[i][j][b]) begin
                        rd_b = rd_line[j][b*8 +: 8];
                    end
                    if (ev_fwd[i][j][b]) begin
                        ev_b = stage[j].wr_line[b*8 +: 8];  // raw write byte
                    end
                end
                if (stage[i].own_mask[b]) begin
                    rd_b = stage[i].wr_line[b*8 +: 8];  // own store overrides all
                end
                rd_line[i][b*8 +: 8]    = rd_b;
                evict_line[i][b*8 +: 8] = ev_b;
            end
        end
    end

    for (genvar i = 0; i < N_LANES; i++) begin : g_evicted
        assign evicted[i] = stage[i].evicted;
    end

endmodule

// ==== dcache_top.sv ====
// data cache line datapath top level
`timescale 1ns/1ps

module dcache_top #(
    parameter  int N_LANES = 4,
    parameter  int N_SETS  = 16,
    localparam int IDX_W   = $clog2(N_SETS)
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  dcache_req_pkg::lane_req_t  req        [N_LANES-1:0],
    output dcache_geom_pkg::line_t     rd_line    [N_LANES-1:0],
    output dcache_geom_pkg::line_t     evict_line [N_LANES-1:0],
    output logic [N_LANES-1:0]         evicted
);

    dcache_req_pkg::lane_stage_t stage [N_LANES-1:0];

    // registered write strobes, shared index and data across ways
    dcache_geom_pkg::byte_en_t wr_mask  [dcache_geom_pkg::N_WAYS-1:0][N_LANES-1:0];
    logic [IDX_W-1:0]          wr_index [N_LANES-1:0];
    dcache_geom_pkg::line_t    wr_data  [N_LANES-1:0];

    logic [IDX_W-1:0]          rd_index [N_LANES-1:0];   // cycle 0, straight from the request

    dcache_geom_pkg::byte_en_t rd_fwd [N_LANES-1:0][N_LANES-1:0];
    dcache_geom_pkg::byte_en_t ev_fwd [N_LANES-1:0][N_LANES-1:0];

    dcache_geom_pkg::line_t    way_lines [dcache_geom_pkg::N_WAYS-1:0][N_LANES-1:0];

    for (genvar l = 0; l < N_LANES; l++) begin : g_rd_index
        assign rd_index[l] = req[l].addr[dcache_geom_pkg::OFFSET_BITS +: IDX_W];
    end

    dcache_req_stage #(
        .N_LANES (N_LANES),
        .N_SETS  (N_SETS)
    ) u_req_stage (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req),
        .stage    (stage),
        .wr_mask  (wr_mask),
        .wr_index (wr_index),
        .wr_data  (wr_data)
    );

    lane_forward_match #(
        .N_LANES (N_LANES),
        .N_SETS  (N_SETS)
    ) u_fwd_match (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .rd_fwd (rd_fwd),
        .ev_fwd (ev_fwd)
    );

    for (genvar w = 0; w < dcache_geom_pkg::N_WAYS; w++) begin : g_way
        way_data_array #(
            .N_LANES (N_LANES),
            .N_SETS  (N_SETS)
        ) u_way_data (
            .clk      (clk),
            .wr_mask  (wr_mask[w]),
            .wr_index (wr_index),
            .wr_data  (wr_data),
            .rd_index (rd_index),
            .rd_data  (way_lines[w])
        );
    end

    lane_line_select #(
        .N_LANES (N_LANES)
    ) u_line_select (
        .stage      (stage),
        .rd_fwd     (rd_fwd),
        .ev_fwd     (ev_fwd),
        .way_lines  (way_lines),
        .rd_line    (rd_line),
        .evict_line (evict_line),
        .evicted    (evicted)
    );

endmodule

// ==== tb_dcache.sv ====
// clock, reset, watchdog, reference model and directed tests for dcache_top
`timescale 1ns/1ps

module tb_dcache;

    localparam int N_LANES    = 4;
    localparam int N_SETS     = 16;
    localparam int IDX_W      = $clog2(N_SETS);
    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 3;

    // cycle budget at one cycle per frame
    localparam int DIRECTED_CYCLES = 26;
    localparam int PREFILL_FRAMES  = 4;
    localparam int RAND_FRAMES     = 150;
    localparam int TEST_CYCLES     = RST_CYCLES + DIRECTED_CYCLES + PREFILL_FRAMES
                                     + RAND_FRAMES + 1;

    logic                       clk;
    logic                       arst_n;
    dcache_req_pkg::lane_req_t  req        [N_LANES-1:0];
    dcache_geom_pkg::line_t     rd_line    [N_LANES-1:0];
    dcache_geom_pkg::line_t     evict_line [N_LANES-1:0];
    logic [N_LANES-1:0]         evicted;

    dcache_req_pkg::lane_req_t  nxt [N_LANES-1:0];   // frame being built

    // reference model with one line per set and way
    dcache_geom_pkg::line_t     model [N_SETS-1:0][dcache_geom_pkg::N_WAYS-1:0];

    // expected outputs of the frame in flight
    dcache_geom_pkg::line_t     pend_rd  [N_LANES-1:0];
    dcache_geom_pkg::line_t     pend_ev  [N_LANES-1:0];
    logic [N_LANES-1:0]         pend_hit;
    logic [N_LANES-1:0]         pend_evicted;
    logic                       pend_valid;

    int     error_count;
    integer seed = 85538;

    dcache_top #(
        .N_LANES (N_LANES),
        .N_SETS  (N_SETS)
    ) u_dcache_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .rd_line    (rd_line),
        .evict_line (evict_line),
        .evicted    (evicted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected number of cycles");
        $display("Some tests failed");
        $finish;
    end

    task automatic check_value(input string name, input dcache_geom_pkg::line_t got,
                               input dcache_geom_pkg::line_t exp);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic dcache_geom_pkg::way_idx_t way_number(dcache_geom_pkg::way_mask_t m);
        way_number = '0;
        for (int w = 0; w < dcache_geom_pkg::N_WAYS; w++) begin
            if (m[w]) begin
                way_number = dcache_geom_pkg::way_idx_t'(w);
            end
        end
    endfunction

    function automatic dcache_geom_pkg::line_t rand_line();
        rand_line = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic clear_frame();
        for (int l = 0; l < N_LANES; l++) begin
            nxt[l] = '0;
        end
    endtask

    task automatic set_lane(input int lane, input dcache_geom_pkg::way_mask_t way_en,
                            input dcache_geom_pkg::way_mask_t evict_en,
                            input dcache_geom_pkg::byte_en_t byte_en, input int set,
                            input dcache_geom_pkg::line_t line);
        nxt[lane].way_en   = way_en;
        nxt[lane].evict_en = evict_en;
        nxt[lane].byte_en  = byte_en;
        nxt[lane].addr     = 32'h8000_0000
                             | (dcache_geom_pkg::addr_t'(set) << dcache_geom_pkg::OFFSET_BITS);
        nxt[lane].wr_line  = line;
    endtask

    // expected outputs from the model state before the frame, then the frame's writes
    task automatic compute_expected();
        logic [IDX_W-1:0]          si;
        logic [IDX_W-1:0]          sj;
        dcache_geom_pkg::way_idx_t hw;
        dcache_geom_pkg::way_idx_t ew;
        dcache_geom_pkg::byte_t    rd_b;
        dcache_geom_pkg::byte_t    ev_b;
        for (int i = 0; i < N_LANES; i++) begin
            si = nxt[i].addr[dcache_geom_pkg::OFFSET_BITS +: IDX_W];
            hw = way_number(nxt[i].way_en);
            ew = way_number(nxt[i].evict_en);
            for (int b = 0; b < dcache_geom_pkg::LINE_BYTES; b++) begin
                rd_b = model[si][hw][b*8 +: 8];
                ev_b = (|nxt[i].evict_en) ? model[si][ew][b*8 +: 8] : 8'h00;
                for (int j = 0; j < i; j++) begin   // highest earlier lane last
                    sj = nxt[j].addr[dcache_geom_pkg::OFFSET_BITS +: IDX_W];
                    if (sj == si && (|nxt[j].way_en) && nxt[j].byte_en[b]) begin
                        if (nxt[j].way_en == nxt[i].way_en) begin
                            rd_b = pend_rd[j][b*8 +: 8];
                        end
                        if (nxt[j].way_en == nxt[i].evict_en) begin
                            ev_b = nxt[j].wr_line[b*8 +: 8];
                        end
                    end
                end
                if ((|nxt[i].way_en) && nxt[i].byte_en[b]) begin
                    rd_b = nxt[i].wr_line[b*8 +: 8];
                end
                pend_rd[i][b*8 +: 8] = rd_b;
                pend_ev[i][b*8 +: 8] = ev_b;
            end
            pend_hit[i]     = |nxt[i].way_en;
            pend_evicted[i] = |nxt[i].evict_en;
        end
        // writes in lane order so the higher lane wins a shared byte
        for (int l = 0; l < N_LANES; l++) begin
            si = nxt[l].addr[dcache_geom_pkg::OFFSET_BITS +: IDX_W];
            hw = way_number(nxt[l].way_en);
            for (int b = 0; b < dcache_geom_pkg::LINE_BYTES; b++) begin
                if ((|nxt[l].way_en) && nxt[l].byte_en[b]) begin
                    model[si][hw][b*8 +: 8] = nxt[l].wr_line[b*8 +: 8];
                end
            end
        end
    endtask

    task automatic check_pending();
        for (int l = 0; l < N_LANES; l++) begin
            if (pend_hit[l]) begin      // idle lanes read nothing useful
                check_value($sformatf("rd_line[%0d]", l), rd_line[l], pend_rd[l]);
            end
            check_value($sformatf("evict_line[%0d]", l), evict_line[l], pend_ev[l]);
        end
        check_value("evicted", dcache_geom_pkg::line_t'(evicted),
                    dcache_geom_pkg::line_t'(pend_evicted));
    endtask

    // drive nxt, then check the frame sampled at this edge
    task automatic send_frame();
        @(posedge clk);
        for (int l = 0; l < N_LANES; l++) begin
            req[l] <= nxt[l];
        end
        @(negedge clk);
        if (pend_valid) begin
            check_pending();
        end
        compute_expected();
        pend_valid = 1'b1;
    endtask

    task automatic idle_after_reset();
        @(negedge clk);
        check_value("evicted after reset", dcache_geom_pkg::line_t'(evicted), '0);
        clear_frame();
        send_frame();
        send_frame();
    endtask

    task automatic full_line_writes();
        for (int w = 0; w < dcache_geom_pkg::N_WAYS; w++) begin
            clear_frame();
            set_lane(0, 4'b0001 << w, 4'b0000, 16'hFFFF, 1, rand_line());
            send_frame();
            clear_frame();
            set_lane(1, 4'b0001 << w, 4'b0000, 16'h0000, 1, '0);  // bypass read
            send_frame();
        end
        clear_frame();
        send_frame();
        for (int l = 0; l < N_LANES; l++) begin
            set_lane(l, 4'b0001 << l, 4'b0000, 16'h0000, 1, '0);
        end
        send_frame();
        clear_frame();
        send_frame();
    endtask

    task automatic partial_write_merge();
        clear_frame();
        set_lane(0, 4'b0010, 4'b0000, 16'hFFFF, 2, rand_line());
        send_frame();
        clear_frame();
        set_lane(0, 4'b0010, 4'b0000, 16'h00FF, 2, rand_line());
        set_lane(3, 4'b0010, 4'b0000, 16'h0F0F, 2, rand_line());  // overlaps bytes 0 to 3
        send_frame();
        clear_frame();
        set_lane(1, 4'b0010, 4'b0000, 16'h0000, 2, '0);
        send_frame();
        clear_frame();
        send_frame();
    endtask

    task automatic same_frame_forward();
        clear_frame();
        set_lane(0, 4'b0100, 4'b0000, 16'hFFFF, 3, rand_line());
        set_lane(1, 4'b0001, 4'b0000, 16'hFFFF, 3, rand_line());
        send_frame();
        clear_frame();
        set_lane(0, 4'b0100, 4'b0000, 16'h00F0, 3, rand_line());
        set_lane(2, 4'b0100, 4'b0000, 16'h0000, 3, '0);
        send_frame();
        clear_frame();
        set_lane(0, 4'b0100, 4'b0000, 16'h0FF0, 3, rand_line());
        set_lane(1, 4'b0001, 4'b0000, 16'h3000, 3, rand_line());   // other way so nothing forwards
        set_lane(2, 4'b0100, 4'b0000, 16'h00C0, 3, rand_line());
        send_frame();
        clear_frame();
        send_frame();
    endtask

    task automatic evict_lines();
        clear_frame();
        set_lane(0, 4'b0001, 4'b0000, 16'hFFFF, 5, rand_line());
        set_lane(1, 4'b1000, 4'b0000, 16'hFFFF, 5, rand_line());
        send_frame();
        clear_frame();
        set_lane(0, 4'b1000, 4'b0000, 16'h000F, 5, rand_line());  // forwarded into lane 3
        set_lane(1, 4'b0000, 4'b0001, 16'h0000, 5, '0);
        set_lane(3, 4'b0000, 4'b1000, 16'h0000, 5, '0);
        send_frame();
        clear_frame();
        send_frame();
        send_frame();
    endtask

    task automatic random_frames();
        logic [31:0] rnd;
        for (int s = 4; s < 8; s++) begin
            clear_frame();
            for (int l = 0; l < N_LANES; l++) begin
                set_lane(l, 4'b0001 << l, 4'b0000, 16'hFFFF, s, rand_line());
            end
            send_frame();
        end
        for (int f = 0; f < RAND_FRAMES; f++) begin
            for (int l = 0; l < N_LANES; l++) begin
                rnd = $random(seed);
                set_lane(l, rnd[2] ? (4'b0001 << rnd[1:0]) : 4'b0000,
                         rnd[5] ? (4'b0001 << rnd[4:3]) : 4'b0000,
                         rnd[31:16], 4 + int'(rnd[7:6]), rand_line());
                rnd = $random(seed);
                nxt[l].addr[31:8] = rnd[23:0];   // tag bits stay out of the index
            end
            send_frame();
        end
    endtask

    initial begin
        arst_n      = 1'b0;
        error_count = 0;
        pend_valid  = 1'b0;
        for (int l = 0; l < N_LANES; l++) begin
            req[l] = '0;
        end
        clear_frame();
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        idle_after_reset();
        full_line_writes();
        partial_write_merge();
        same_frame_forward();
        evict_lines();
        random_frames();
        clear_frame();
        send_frame();   // checks the last frame

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
dcache_geom_pkg.sv
dcache_req_pkg.sv
dcache_req_stage.sv
way_data_array.sv
lane_forward_match.sv
lane_line_select.sv
dcache_top.sv
tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run the testbench, then look for the pass message
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module tb_dcache -o sim_dcache \
    && ./obj_dir/sim_dcache > sim.log 2>&1 \
    || echo "build or simulation ended with an error"
touch sim.log
cat sim.log
grep -q "All tests passed" sim.log && echo "simulation passed" || exit 1
